/* common/isa_pkg.sv */
package isa_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------

    // integer register data width
    localparam int unsigned XLEN = 64;
    // architectural register index
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS = 2 ** REG_ADDR_BITS;
    // scoreboard slot tag, 8 entries in flight
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [XLEN-1:0] xlen_t;

    // ----------------------------------------
    // functional units and operations
    // ----------------------------------------

    // target unit of an instruction
    // FU_NONE marks instructions that complete without a unit
    typedef enum logic [3:0] {
        FU_NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    // reduced operation set, only passed through by the issue stage
    typedef enum logic [6:0] {
        ADD,
        SUB,
        SLTS,
        LW,
        SW,
        JALR,
        MUL,
        CSR_WRITE
    } fu_op_t;

    // per register: which unit will write it next, FU_NONE when free
    typedef fu_t [NR_REGS-1:0] clobber_t;

endpackage

/* common/issue_pkg.sv */
package issue_pkg;

    // ----------------------------------------
    // scoreboard side
    // ----------------------------------------

    // instruction handed over by the scoreboard
    typedef struct packed {
        isa_pkg::xlen_t                      pc;
        logic [isa_pkg::TRANS_ID_BITS-1:0]   trans_id;
        isa_pkg::fu_t                        fu;
        isa_pkg::fu_op_t                     op;
        isa_pkg::reg_addr_t                  rs1;
        isa_pkg::reg_addr_t                  rs2;
        isa_pkg::reg_addr_t                  rd;
        // immediate until the unit writes back a result
        isa_pkg::xlen_t                      result;
        // exception raised earlier in the pipeline
        logic                                valid_ex;
        logic                                use_imm;
        logic                                use_zimm;
        logic                                use_pc;
    } scoreboard_entry_t;

    // answer of the scoreboard to a source register lookup
    typedef struct packed {
        logic           valid;
        isa_pkg::xlen_t data;
    } sb_operand_t;

    // one register write from the commit stage
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::xlen_t     wdata;
    } commit_port_t;

    // ----------------------------------------
    // execute side
    // ----------------------------------------

    // operands and control going to the functional units
    typedef struct packed {
        isa_pkg::fu_t                        fu;
        isa_pkg::fu_op_t                     op;
        isa_pkg::xlen_t                      operand_a;
        isa_pkg::xlen_t                      operand_b;
        isa_pkg::xlen_t                      imm;
        logic [isa_pkg::TRANS_ID_BITS-1:0]   trans_id;
    } fu_data_t;

    // one start strobe per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

endpackage

/* hw/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    // one read port per source operand
    input  isa_pkg::reg_addr_t [1:0]                       raddr_i,
    // write ports from the commit stage
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i,
    output isa_pkg::xlen_t [1:0]                           rdata_o
);
    import isa_pkg::*;

    // x1 .. x31, x0 has no storage
    xlen_t [NR_REGS-1:1] regs_q;
    // full 32 entry view with x0 tied to zero
    xlen_t [NR_REGS-1:0] rf_view;

    // ----------------------------------------
    // write side
    // ----------------------------------------

    // ports are walked in order so the highest port wins on equal addresses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                // writes to x0 are dropped
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------

    assign rf_view = {regs_q, xlen_t'('0)};

    // combinational reads, a commit shows up one cycle later
    always_comb begin
        for (int unsigned r = 0; r < 2; r++) begin
            rdata_o[r] = rf_view[raddr_i[r]];
        end
    end

endmodule

/* hw/operand_lane.sv */
`timescale 1ns/1ps

module operand_lane (
    // source register of this lane
    input  isa_pkg::reg_addr_t     rs_addr_i,
    // pending writers of every register
    input  isa_pkg::clobber_t      clobber_i,
    // scoreboard result for rs_addr_i
    input  issue_pkg::sb_operand_t sb_i,
    // register file read data for rs_addr_i
    input  isa_pkg::xlen_t         rf_data_i,
    output isa_pkg::xlen_t         operand_o,
    // operand not yet available
    output logic                   stall_o
);
    import isa_pkg::*;

    // unit that will write the source register
    fu_t clobber_fu;
    // register has an in-flight writer
    logic clobbered;
    // writer result can be taken from the scoreboard
    logic forward;

    assign clobber_fu = clobber_i[rs_addr_i];
    assign clobbered  = (clobber_fu != FU_NONE);

    // ----------------------------------------
    // forward or stall
    // ----------------------------------------

    // CSR results only become visible through the register file
    assign forward = clobbered && sb_i.valid && (clobber_fu != CSR);

    always_comb begin
        // free register, plain register file value
        operand_o = rf_data_i;
        stall_o   = 1'b0;
        if (clobbered) begin
            if (forward) begin
                operand_o = sb_i.data;
            end else begin
                // result still outstanding
                stall_o = 1'b1;
            end
        end
    end

endmodule

/* hw/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    // scoreboard handshake
    input  issue_pkg::scoreboard_entry_t                   issue_instr_i,
    input  logic                                           issue_instr_valid_i,
    output logic                                           issue_ack_o,
    // pending writers per register
    input  isa_pkg::clobber_t                              clobber_i,
    // commit writes of this cycle, used for the WAW bypass
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i,
    // resolved source operands, lane 0 is rs1
    input  isa_pkg::xlen_t [1:0]                           lane_operand_i,
    input  logic [1:0]                                     lane_stall_i,
    // unit readiness
    input  logic                                           flu_ready_i,
    input  logic                                           lsu_ready_i,
    // ID/EX outputs
    output issue_pkg::fu_data_t                            fu_data_o,
    output issue_pkg::fu_valid_t                           fu_valid_o,
    output isa_pkg::xlen_t                                 pc_o
);
    import isa_pkg::*;
    import issue_pkg::*;

    logic      fu_busy;
    logic      stall;
    logic      rd_free;
    xlen_t     operand_a_n;
    xlen_t     operand_b_n;
    fu_data_t  fu_data_n;
    fu_data_t  fu_data_q;
    fu_valid_t fu_valid_n;
    fu_valid_t fu_valid_q;
    xlen_t     pc_q;

    // ----------------------------------------
    // issue checks
    // ----------------------------------------

    // busy flag of the target unit
    always_comb begin
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // a zimm in the rs1 field needs no register
    assign stall = (lane_stall_i[0] && !issue_instr_i.use_zimm) || lane_stall_i[1];

    // WAW check, a commit to rd in this cycle frees it as well
    always_comb begin
        rd_free = (clobber_i[issue_instr_i.rd] == FU_NONE);
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == issue_instr_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions only retire
            if (issue_instr_i.valid_ex || (issue_instr_i.fu == FU_NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the multiplier shares the fixed latency writeback,
        // so only another MULT may follow a MULT
        if (fu_valid_q.mult && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // ----------------------------------------
    // operand selection
    // ----------------------------------------

    always_comb begin
        // operand a: zimm over pc over rs1
        operand_a_n = lane_operand_i[0];
        if (issue_instr_i.use_pc) begin
            operand_a_n = issue_instr_i.pc;
        end
        if (issue_instr_i.use_zimm) begin
            operand_a_n = {{(XLEN-REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};
        end
        // stores and branches keep rs2 and take the immediate via imm
        operand_b_n = lane_operand_i[1];
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE)
                && (issue_instr_i.fu != CTRL_FLOW)) begin
            operand_b_n = issue_instr_i.result;
        end
    end

    assign fu_data_n.fu        = issue_instr_i.fu;
    assign fu_data_n.op        = issue_instr_i.op;
    assign fu_data_n.operand_a = operand_a_n;
    assign fu_data_n.operand_b = operand_b_n;
    assign fu_data_n.imm       = issue_instr_i.result;
    assign fu_data_n.trans_id  = issue_instr_i.trans_id;

    // one strobe for the target unit of an accepted instruction
    always_comb begin
        fu_valid_n = '0;
        if (issue_instr_valid_i && issue_ack_o && !issue_instr_i.valid_ex) begin
            case (issue_instr_i.fu)
                ALU:         fu_valid_n.alu    = 1'b1;
                CTRL_FLOW:   fu_valid_n.branch = 1'b1;
                LOAD, STORE: fu_valid_n.lsu    = 1'b1;
                MULT:        fu_valid_n.mult   = 1'b1;
                CSR:         fu_valid_n.csr    = 1'b1;
                default:     fu_valid_n        = '0;
            endcase
        end
    end

    // ----------------------------------------
    // ID/EX registers
    // ----------------------------------------

    // data loads every cycle, the valids qualify it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_q <= '0;
            pc_q      <= '0;
        end else begin
            fu_data_q <= fu_data_n;
            pc_q      <= issue_instr_i.pc;
        end
    end

    // flush kills whatever was accepted on this edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_valid_q <= '0;
        end else if (flush_i) begin
            fu_valid_q <= '0;
        end else begin
            fu_valid_q <= fu_valid_n;
        end
    end

    assign fu_data_o  = fu_data_q;
    assign fu_valid_o = fu_valid_q;
    assign pc_o       = pc_q;

endmodule

/* hw/issue_read_operands.sv */
`timescale 1ns/1ps

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    // instruction from the scoreboard
    input  issue_pkg::scoreboard_entry_t                   issue_instr_i,
    input  logic                                           issue_instr_valid_i,
    output logic                                           issue_ack_o,
    // source lookup in the scoreboard
    output isa_pkg::reg_addr_t                             rs1_o,
    output isa_pkg::reg_addr_t                             rs2_o,
    input  issue_pkg::sb_operand_t                         rs1_i,
    input  issue_pkg::sb_operand_t                         rs2_i,
    input  isa_pkg::clobber_t                              clobber_i,
    // unit readiness
    input  logic                                           flu_ready_i,
    input  logic                                           lsu_ready_i,
    // commit stage writes
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i,
    // to the functional units
    output issue_pkg::fu_data_t                            fu_data_o,
    output issue_pkg::fu_valid_t                           fu_valid_o,
    output isa_pkg::xlen_t                                 pc_o
);
    import isa_pkg::*;
    import issue_pkg::*;

    // index 0 is rs1, index 1 is rs2
    reg_addr_t   [1:0] rs_addr;
    sb_operand_t [1:0] sb_answer;
    xlen_t       [1:0] rf_rdata;
    xlen_t       [1:0] lane_operand;
    logic        [1:0] lane_stall;

    assign rs1_o     = issue_instr_i.rs1;
    assign rs2_o     = issue_instr_i.rs2;
    assign rs_addr   = {issue_instr_i.rs2, issue_instr_i.rs1};
    assign sb_answer = {rs2_i, rs1_i};

    // ----------------------------------------
    // integer register file
    // ----------------------------------------

    gpr_file #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) i_gpr_file (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .raddr_i  (rs_addr),
        .commit_i (commit_i),
        .rdata_o  (rf_rdata)
    );

    // one forwarding lane per source register
    for (genvar l = 0; l < 2; l++) begin : gen_lane
        operand_lane i_operand_lane (
            .rs_addr_i (rs_addr[l]),
            .clobber_i (clobber_i),
            .sb_i      (sb_answer[l]),
            .rf_data_i (rf_rdata[l]),
            .operand_o (lane_operand[l]),
            .stall_o   (lane_stall[l])
        );
    end

    // ----------------------------------------
    // issue control and ID/EX stage
    // ----------------------------------------

    issue_ctrl #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) i_issue_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .issue_ack_o         (issue_ack_o),
        .clobber_i           (clobber_i),
        .commit_i            (commit_i),
        .lane_operand_i      (lane_operand),
        .lane_stall_i        (lane_stall),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .fu_data_o           (fu_data_o),
        .fu_valid_o          (fu_valid_o),
        .pc_o                (pc_o)
    );

endmodule

/* tb/tb_issue_tasks.svh */
`ifndef TB_ISSUE_TASKS_SVH
`define TB_ISSUE_TASKS_SVH

// ----------------------------------------
// drivers and reference rules
// ----------------------------------------

// inputs change 1 ns after the rising edge
task automatic next_edge();
    @(posedge clk_i);
    #1;
endtask

task automatic idle_inputs();
    flush_i = 1'b0;
    issue_instr = '0;
    issue_instr_valid = 1'b0;
    rs1_sb = '0;
    rs2_sb = '0;
    flu_ready = 1'b1;
    lsu_ready = 1'b1;
    for (int unsigned r = 0; r < NR_REGS; r++) begin
        clobber[r] = FU_NONE;
    end
    for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
        commit[p] = '0;
    end
endtask

function automatic xlen_t random_word();
    return {$urandom, $urandom};
endfunction

// plain instruction, random pc, immediate and tag
function automatic scoreboard_entry_t make_instr(input fu_t fu, input fu_op_t op,
        input reg_addr_t rs1_a, input reg_addr_t rs2_a, input reg_addr_t rd_a);
    scoreboard_entry_t e;
    e = '0;
    e.pc = random_word();
    e.result = random_word();
    e.trans_id = 3'($urandom);
    e.fu = fu;
    e.op = op;
    e.rs1 = rs1_a;
    e.rs2 = rs2_a;
    e.rd = rd_a;
    return e;
endfunction

// the strobe each unit expects
function automatic fu_valid_t unit_valid(input fu_t fu);
    fu_valid_t v;
    v = '0;
    case (fu)
        ALU:         v.alu = 1'b1;
        CTRL_FLOW:   v.branch = 1'b1;
        LOAD, STORE: v.lsu = 1'b1;
        MULT:        v.mult = 1'b1;
        CSR:         v.csr = 1'b1;
        default:     v = '0;
    endcase
    return v;
endfunction

// zimm first, then pc, then the rs1 value
function automatic xlen_t expected_operand_a(input scoreboard_entry_t instr, input xlen_t rs1_val);
    if (instr.use_zimm) begin
        return xlen_t'(instr.rs1);
    end
    if (instr.use_pc) begin
        return instr.pc;
    end
    return rs1_val;
endfunction

// stores and branches keep rs2 even with use_imm
function automatic xlen_t expected_operand_b(input scoreboard_entry_t instr, input xlen_t rs2_val);
    if (instr.use_imm && (instr.fu != STORE) && (instr.fu != CTRL_FLOW)) begin
        return instr.result;
    end
    return rs2_val;
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------

task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_fu_valid(input fu_valid_t got, input fu_valid_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error fu_valid_o: got %h, expected %h", got, exp);
    end
endtask

task automatic check_ack(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error issue_ack_o: got %h, expected %h", got, exp);
    end
endtask

task automatic check_fu_data(input fu_data_t got, input fu_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error fu_data_o: got %h, expected %h", got, exp);
    end
endtask

// ----------------------------------------
// stimulus steps
// ----------------------------------------

// one write per port, the higher port is applied last
task automatic commit_cycle(input reg_addr_t a0, input xlen_t d0,
        input reg_addr_t a1, input xlen_t d1);
    commit[0].we = 1'b1;
    commit[0].waddr = a0;
    commit[0].wdata = d0;
    commit[1].we = 1'b1;
    commit[1].waddr = a1;
    commit[1].wdata = d1;
    next_edge();
    commit[0].we = 1'b0;
    commit[1].we = 1'b0;
    if (a0 != '0) begin
        ref_regs[a0] = d0;
    end
    if (a1 != '0) begin
        ref_regs[a1] = d1;
    end
endtask

// present one instruction, check ack now and the ID/EX outputs after the edge
task automatic issue_check(input scoreboard_entry_t instr, input logic exp_ack,
        input xlen_t rs1_val, input xlen_t rs2_val);
    fu_valid_t exp_valid;
    fu_data_t  exp_data;
    issue_instr = instr;
    issue_instr_valid = 1'b1;
    #2;
    check_ack(issue_ack, exp_ack);
    check_xlen("rs1_o", xlen_t'(rs1), xlen_t'(instr.rs1));
    check_xlen("rs2_o", xlen_t'(rs2), xlen_t'(instr.rs2));
    exp_valid = '0;
    // flush on the accepting edge kills the strobe
    if (exp_ack && !instr.valid_ex && !flush_i) begin
        exp_valid = unit_valid(instr.fu);
    end
    exp_data.fu = instr.fu;
    exp_data.op = instr.op;
    exp_data.operand_a = expected_operand_a(instr, rs1_val);
    exp_data.operand_b = expected_operand_b(instr, rs2_val);
    exp_data.imm = instr.result;
    exp_data.trans_id = instr.trans_id;
    next_edge();
    issue_instr_valid = 1'b0;
    check_fu_valid(fu_valid, exp_valid);
    if (exp_valid != '0) begin
        check_fu_data(fu_data, exp_data);
        check_xlen("pc_o", pc, instr.pc);
    end
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------

task automatic reset_state();
    check_fu_valid(fu_valid, '0);
    check_ack(issue_ack, 1'b0);
    check_xlen("fu_data_o.fu", xlen_t'(fu_data.fu), xlen_t'(FU_NONE));
endtask

task automatic register_file_reads();
    scoreboard_entry_t instr;
    for (int i = 0; i < 8; i++) begin
        commit_cycle(reg_addr_t'($urandom_range(31, 1)), random_word(),
                     reg_addr_t'($urandom_range(31, 1)), random_word());
    end
    // two ports at once, a write to x0, then one address on both ports
    commit_cycle(5'd5, random_word(), 5'd7, random_word());
    commit_cycle(5'd0, random_word(), 5'd9, random_word());
    commit_cycle(5'd12, random_word(), 5'd12, random_word());
    issue_check(make_instr(ALU, ADD, 5'd5, 5'd7, 5'd1), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(ALU, ADD, 5'd0, 5'd9, 5'd1), 1'b1, '0, ref_regs[9]);
    issue_check(make_instr(ALU, SUB, 5'd12, 5'd12, 5'd2), 1'b1, ref_regs[12], ref_regs[12]);
    for (int i = 0; i < 16; i++) begin
        instr = make_instr(ALU, ADD, reg_addr_t'($urandom), reg_addr_t'($urandom), 5'd3);
        issue_check(instr, 1'b1, ref_regs[instr.rs1], ref_regs[instr.rs2]);
    end
endtask

task automatic forwarding_and_stall();
    scoreboard_entry_t instr;
    xlen_t fwd_a;
    xlen_t fwd_b;
    fwd_a = random_word();
    fwd_b = random_word();
    instr = make_instr(ALU, ADD, 5'd3, 5'd4, 5'd20);
    // both sources in flight with results ready
    clobber[3] = ALU;
    clobber[4] = LOAD;
    rs1_sb.valid = 1'b1;
    rs1_sb.data = fwd_a;
    rs2_sb.valid = 1'b1;
    rs2_sb.data = fwd_b;
    issue_check(instr, 1'b1, fwd_a, fwd_b);
    // rs2 result still outstanding
    rs2_sb.valid = 1'b0;
    issue_check(instr, 1'b0, fwd_a, fwd_b);
    // a CSR writer is never forwarded
    rs2_sb.valid = 1'b1;
    clobber[4] = CSR;
    issue_check(instr, 1'b0, fwd_a, fwd_b);
    // zimm needs no rs1 value
    clobber[4] = FU_NONE;
    rs1_sb.valid = 1'b0;
    instr.use_zimm = 1'b1;
    issue_check(instr, 1'b1, fwd_a, ref_regs[4]);
    idle_inputs();
endtask

task automatic operand_selection();
    scoreboard_entry_t instr;
    instr = make_instr(ALU, ADD, 5'd5, 5'd7, 5'd21);
    instr.use_pc = 1'b1;
    issue_check(instr, 1'b1, ref_regs[5], ref_regs[7]);
    instr.use_imm = 1'b1;
    issue_check(instr, 1'b1, ref_regs[5], ref_regs[7]);
    // zimm wins over pc
    instr.use_zimm = 1'b1;
    issue_check(instr, 1'b1, ref_regs[5], ref_regs[7]);
    instr = make_instr(STORE, SW, 5'd9, 5'd12, 5'd22);
    instr.use_imm = 1'b1;
    issue_check(instr, 1'b1, ref_regs[9], ref_regs[12]);
    instr = make_instr(CTRL_FLOW, JALR, 5'd12, 5'd9, 5'd23);
    instr.use_imm = 1'b1;
    instr.use_pc = 1'b1;
    issue_check(instr, 1'b1, ref_regs[12], ref_regs[9]);
    instr = make_instr(LOAD, LW, 5'd7, 5'd5, 5'd24);
    instr.use_imm = 1'b1;
    issue_check(instr, 1'b1, ref_regs[7], ref_regs[5]);
endtask

task automatic issue_rules();
    scoreboard_entry_t instr;
    // busy FLU, the LSU still accepts
    flu_ready = 1'b0;
    issue_check(make_instr(ALU, ADD, 5'd5, 5'd7, 5'd1), 1'b0, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(CSR, CSR_WRITE, 5'd5, 5'd7, 5'd1), 1'b0, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(LOAD, LW, 5'd5, 5'd7, 5'd1), 1'b1, ref_regs[5], ref_regs[7]);
    flu_ready = 1'b1;
    lsu_ready = 1'b0;
    issue_check(make_instr(STORE, SW, 5'd5, 5'd7, 5'd1), 1'b0, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(CTRL_FLOW, JALR, 5'd5, 5'd7, 5'd1), 1'b1, ref_regs[5], ref_regs[7]);
    lsu_ready = 1'b1;
    // WAW on rd, released by a commit to rd in the same cycle
    clobber[25] = ALU;
    instr = make_instr(ALU, ADD, 5'd5, 5'd7, 5'd25);
    issue_check(instr, 1'b0, ref_regs[5], ref_regs[7]);
    commit[1].we = 1'b1;
    commit[1].waddr = 5'd25;
    commit[1].wdata = random_word();
    issue_check(instr, 1'b1, ref_regs[5], ref_regs[7]);
    ref_regs[25] = commit[1].wdata;
    commit[1].we = 1'b0;
    idle_inputs();
    // exception and unit-less instructions while stalled and busy
    flu_ready = 1'b0;
    clobber[3] = ALU;
    instr = make_instr(ALU, ADD, 5'd3, 5'd7, 5'd1);
    instr.valid_ex = 1'b1;
    issue_check(instr, 1'b1, ref_regs[3], ref_regs[7]);
    issue_check(make_instr(FU_NONE, ADD, 5'd3, 5'd7, 5'd1), 1'b1, ref_regs[3], ref_regs[7]);
    idle_inputs();
endtask

task automatic valids_lock_flush();
    // MULT last, it locks the next slot
    issue_check(make_instr(ALU, ADD, 5'd5, 5'd7, 5'd26), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(CTRL_FLOW, JALR, 5'd5, 5'd7, 5'd26), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(LOAD, LW, 5'd5, 5'd7, 5'd26), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(STORE, SW, 5'd5, 5'd7, 5'd26), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(CSR, CSR_WRITE, 5'd5, 5'd7, 5'd26), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(MULT, MUL, 5'd5, 5'd7, 5'd26), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(ALU, ADD, 5'd5, 5'd7, 5'd27), 1'b0, ref_regs[5], ref_regs[7]);
    // back to back MULTs pass, the lock lifts after an empty slot
    issue_check(make_instr(MULT, MUL, 5'd5, 5'd7, 5'd27), 1'b1, ref_regs[5], ref_regs[7]);
    issue_check(make_instr(MULT, MUL, 5'd9, 5'd12, 5'd28), 1'b1, ref_regs[9], ref_regs[12]);
    issue_check(make_instr(ALU, SLTS, 5'd9, 5'd12, 5'd28), 1'b0, ref_regs[9], ref_regs[12]);
    issue_check(make_instr(ALU, SLTS, 5'd9, 5'd12, 5'd28), 1'b1, ref_regs[9], ref_regs[12]);
    flush_i = 1'b1;
    issue_check(make_instr(ALU, ADD, 5'd5, 5'd7, 5'd29), 1'b1, ref_regs[5], ref_regs[7]);
    flush_i = 1'b0;
endtask

`endif

/* tb/tb_issue.sv */
`timescale 1ns/1ps

module tb_issue;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int unsigned NR_COMMIT_PORTS = 2;
    // tests take under 100 cycles, the rest is margin
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic flush_i;

    // scoreboard side
    scoreboard_entry_t issue_instr;
    logic              issue_instr_valid;
    logic              issue_ack;
    reg_addr_t         rs1;
    reg_addr_t         rs2;
    sb_operand_t       rs1_sb;
    sb_operand_t       rs2_sb;
    clobber_t          clobber;
    logic              flu_ready;
    logic              lsu_ready;
    commit_port_t [NR_COMMIT_PORTS-1:0] commit;

    // unit side
    fu_data_t  fu_data;
    fu_valid_t fu_valid;
    xlen_t     pc;

    // expected register file contents
    xlen_t       ref_regs [NR_REGS];
    int unsigned checks;
    int unsigned errors;
    int unsigned cycle_count = 0;

    issue_read_operands #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) dut (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr),
        .issue_instr_valid_i (issue_instr_valid),
        .issue_ack_o         (issue_ack),
        .rs1_o               (rs1),
        .rs2_o               (rs2),
        .rs1_i               (rs1_sb),
        .rs2_i               (rs2_sb),
        .clobber_i           (clobber),
        .flu_ready_i         (flu_ready),
        .lsu_ready_i         (lsu_ready),
        .commit_i            (commit),
        .fu_data_o           (fu_data),
        .fu_valid_o          (fu_valid),
        .pc_o                (pc)
    );

    `include "tb_issue_tasks.svh"

    // 8 ns clock
    always #4 clk_i = ~clk_i;

    // ----------------------------------------
    // run limit
    // ----------------------------------------

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(62233));
        checks = 0;
        errors = 0;
        rst_ni = 1'b0;
        idle_inputs();
        for (int unsigned r = 0; r < NR_REGS; r++) begin
            ref_regs[r] = '0;
        end
        repeat (16) @(posedge clk_i);
        reset_state();
        #1;
        rst_ni = 1'b1;
        next_edge();
        register_file_reads();
        forwarding_and_stall();
        operand_selection();
        issue_rules();
        valids_lock_flush();
        next_edge();
        $display("tb_issue: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+tb
common/isa_pkg.sv
common/issue_pkg.sv
hw/gpr_file.sv
hw/operand_lane.sv
hw/issue_ctrl.sv
hw/issue_read_operands.sv
tb/tb_issue.sv

/* Makefile */
# Verilator build of the issue stage testbench

SIM := obj_dir/Vtb_issue

.PHONY: run clean

# rebuilt only when a source or the file list changes
$(SIM): build.f $(wildcard common/*.sv hw/*.sv tb/*.sv tb/*.svh)
	verilator --binary --timing --top-module tb_issue -f build.f -Mdir obj_dir

# the log must hold the pass message
run: $(SIM)
	./$(SIM) > sim.log
	cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
